/* hdl/pcie_pkg.sv */
`default_nettype none

package pcie_pkg;

  typedef logic [31:0]  dword_t;     // one header or payload dword
  typedef logic [255:0] tlp_data_t;  // one stream beat, dword 0 in [31:0]
  typedef logic [15:0]  pcie_id_t;   // bus[15:8] dev[7:3] fn[2:0]
  typedef logic [7:0]   tlp_tag_t;
  typedef logic [63:0]  tlp_addr_t;  // byte address, [1:0] always zero
  typedef logic [3:0]   csr_addr_t;

  typedef enum logic [2:0] {
    kind_mrd,
    kind_mwr,
    kind_cpl,
    kind_cpld,
    kind_unknown
  } tlp_kind_e;

  // b3:00.0, non-ARI layout
  localparam pcie_id_t default_completer_id = {8'hb3, 5'h0, 3'h0};

  // classification key is {fmt[1], type[4:0]} of header dword 0
  localparam logic [5:0] code_mrd  = 6'b0_00000;
  localparam logic [5:0] code_mwr  = 6'b1_00000;
  localparam logic [5:0] code_cpl  = 6'b0_01010;
  localparam logic [5:0] code_cpld = 6'b1_01010;

  // completion with data, 3dw header
  localparam logic [2:0] cpld_fmt      = 3'b010;
  localparam logic [4:0] cpld_type     = 5'b01010;
  localparam logic [2:0] cpl_status_sc = 3'b000;  // successful completion

  // csr register map
  localparam csr_addr_t csr_id       = 4'h0;
  localparam csr_addr_t csr_rx_count = 4'h1;
  localparam csr_addr_t csr_tx_count = 4'h2;
  localparam csr_addr_t csr_rx_hdr0  = 4'h3;
  localparam csr_addr_t csr_rx_hdr1  = 4'h4;
  localparam csr_addr_t csr_rx_hdr2  = 4'h5;
  localparam csr_addr_t csr_tx_hdr0  = 4'h6;
  localparam csr_addr_t csr_tx_hdr1  = 4'h7;
  localparam csr_addr_t csr_tx_hdr2  = 4'h8;

endpackage

`default_nettype wire

/* hdl/tlp_hdr_if.sv */
`timescale 1ns/100ps
`default_nettype none

// decoded rx header, fields valid from start until the next start
interface tlp_hdr_if;
  import pcie_pkg::*;

  logic          start;         // one cycle per received header
  tlp_kind_e     kind;
  tlp_tag_t      tag;
  pcie_id_t      requester_id;
  tlp_addr_t     addr;
  dword_t [2:0]  hdr;           // raw header dwords 0..2

  modport src (
    output start, kind, tag, requester_id, addr, hdr
  );

  modport dst (
    input start, kind, tag, requester_id, addr, hdr
  );

endinterface

`default_nettype wire

/* hdl/tlp_tx_if.sv */
`timescale 1ns/100ps
`default_nettype none

// outgoing completion stream, no ready
interface tlp_tx_if;
  import pcie_pkg::*;

  logic        valid;
  logic        sop;
  logic        eop;
  logic [1:0]  empty;  // in units of 2 dwords, as on the hard ip
  tlp_data_t   data;

  modport src (
    output valid, sop, eop, empty, data
  );

  // top outputs and csr capture only look
  modport mon (
    input valid, sop, eop, empty, data
  );

endinterface

`default_nettype wire

/* hdl/tlp_rx_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

// header layout, request:
//   dw0  fmt[31:29] type[28:24] ... length[9:0]
//   dw1  requester id[31:16] tag[15:8] be[7:0]
//   dw2  addr[63:32] (4dw) or addr[31:2] (3dw)
//   dw3  addr[31:2] (4dw only)
// completion:
//   dw1  completer id, status, byte count
//   dw2  requester id[31:16] tag[15:8] lower addr[6:0]
module tlp_rx_decoder (
  input  logic                clk,
  input  logic                reset,
  input  pcie_pkg::tlp_data_t rx_data,
  input  logic                rx_valid,
  input  logic                rx_sop,
  tlp_hdr_if.src              hdr
);
  import pcie_pkg::*;

  dword_t [7:0] dw;        // beat split into dwords
  logic   [2:0] fmt;
  logic   [4:0] tlp_type;
  logic         is_4dw;
  logic         hdr_beat;  // first beat of a tlp

  tlp_kind_e kind_d;
  tlp_tag_t  tag_d;
  pcie_id_t  req_id_d;
  tlp_addr_t addr_d;

  assign dw       = rx_data;
  assign fmt      = dw[0][31:29];
  assign tlp_type = dw[0][28:24];
  assign is_4dw   = fmt[0];
  assign hdr_beat = rx_valid && rx_sop;

  // only fmt[1] (has data) matters for the kind, fmt[0] is header size
  always_comb begin
    case ({fmt[1], tlp_type})
      code_mrd:  kind_d = kind_mrd;
      code_mwr:  kind_d = kind_mwr;
      code_cpl:  kind_d = kind_cpl;
      code_cpld: kind_d = kind_cpld;
      default:   kind_d = kind_unknown;
    endcase
  end

  // tag and requester id sit one dword later in completions
  always_comb begin
    if (kind_d == kind_cpl || kind_d == kind_cpld) begin
      tag_d    = dw[2][15:8];
      req_id_d = dw[2][31:16];
    end else begin
      tag_d    = dw[1][15:8];
      req_id_d = dw[1][31:16];
    end
  end

  always_comb begin
    if (is_4dw) begin
      addr_d = {dw[2], dw[3][31:2], 2'b00};
    end else begin
      addr_d = {32'h0, dw[2][31:2], 2'b00};  // 32-bit address
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hdr.start <= 1'b0;
    end else begin
      hdr.start <= hdr_beat;  // pulse in the cycle after the header beat
    end
  end

  // fields hold until the next header
  always_ff @(posedge clk) begin
    if (hdr_beat) begin
      hdr.kind         <= kind_d;
      hdr.tag          <= tag_d;
      hdr.requester_id <= req_id_d;
      hdr.addr         <= addr_d;
      hdr.hdr          <= dw[2:0];
    end
  end

  // a start of packet strobe is meaningless on an idle cycle
  sop_needs_valid: assert property (
    @(posedge clk) disable iff (reset) rx_sop |-> rx_valid
  );

endmodule

`default_nettype wire

/* hdl/cpl_builder.sv */
`timescale 1ns/100ps
`default_nettype none

// one single-dword CplD per decoded memory read
//   dw0  fmt/type CplD, length 1
//   dw1  completer id[31:16] status[15:13] byte count[11:0]
//   dw2  requester id[31:16] tag[15:8] lower addr[6:0]
//   dw3  payload
module cpl_builder #(
  parameter pcie_pkg::pcie_id_t COMPLETER_ID = pcie_pkg::default_completer_id
) (
  input  logic   clk,
  input  logic   reset,
  tlp_hdr_if.dst hdr,
  tlp_tx_if.src  tx
);
  import pcie_pkg::*;

  dword_t [7:0] cpl_dw;  // next completion beat
  logic         load;

  assign load = hdr.start && (hdr.kind == kind_mrd);

  always_comb begin
    cpl_dw = '0;  // unused dwords stay zero
    cpl_dw[0][31:29] = cpld_fmt;
    cpl_dw[0][28:24] = cpld_type;
    cpl_dw[0][9:0]   = 10'd1;  // length in dwords
    cpl_dw[1][31:16] = COMPLETER_ID;
    cpl_dw[1][15:13] = cpl_status_sc;
    cpl_dw[1][11:0]  = 12'd4;  // byte count of one full dword
    cpl_dw[2][31:16] = hdr.requester_id;
    cpl_dw[2][15:8]  = hdr.tag;
    cpl_dw[2][6:0]   = hdr.addr[6:0];  // lower address
    // big-endian payload echoing the request
    cpl_dw[3]        = {hdr.tag, hdr.requester_id, hdr.addr[7:0]};
  end

  // single cycle strobes since every completion is one beat
  always_ff @(posedge clk) begin
    if (reset) begin
      tx.valid <= 1'b0;
      tx.sop   <= 1'b0;
      tx.eop   <= 1'b0;
      tx.empty <= 2'd0;
    end else begin
      tx.valid <= load;
      tx.sop   <= load;
      tx.eop   <= load;
      tx.empty <= load ? 2'd2 : 2'd0;  // 4 of 8 dwords used
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      tx.data <= cpl_dw;
    end
  end

  // the completion echoes these request fields
  read_fields_known: assert property (
    @(posedge clk) disable iff (reset)
      load |-> !$isunknown({hdr.requester_id, hdr.tag, hdr.addr[7:0]})
  );

endmodule

`default_nettype wire

/* hdl/tlp_csr.sv */
`timescale 1ns/100ps
`default_nettype none

// status registers with a registered read port that holds between reads
module tlp_csr #(
  parameter pcie_pkg::pcie_id_t COMPLETER_ID = pcie_pkg::default_completer_id
) (
  input  logic                clk,
  input  logic                reset,
  tlp_hdr_if.dst              hdr,
  tlp_tx_if.mon               tx,
  input  logic                csr_read,
  input  pcie_pkg::csr_addr_t csr_address,
  output pcie_pkg::dword_t    csr_readdata
);
  import pcie_pkg::*;

  dword_t       rx_count;
  dword_t       tx_count;
  dword_t [2:0] rx_hdr_q;  // last received header dwords 0..2
  dword_t [2:0] tx_hdr_q;  // last sent header
  logic         tx_start;

  assign tx_start = tx.valid && tx.sop;

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_count <= '0;
      rx_hdr_q <= '0;
    end else if (hdr.start) begin
      rx_count <= rx_count + 32'd1;  // wraps
      rx_hdr_q <= hdr.hdr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_count <= '0;
      tx_hdr_q <= '0;
    end else if (tx_start) begin
      tx_count <= tx_count + 32'd1;
      tx_hdr_q <= tx.data[95:0];  // dword 0 is the low word
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      csr_readdata <= '0;
    end else if (csr_read) begin
      case (csr_address)
        csr_id:       csr_readdata <= {16'h0, COMPLETER_ID};
        csr_rx_count: csr_readdata <= rx_count;
        csr_tx_count: csr_readdata <= tx_count;
        csr_rx_hdr0:  csr_readdata <= rx_hdr_q[0];
        csr_rx_hdr1:  csr_readdata <= rx_hdr_q[1];
        csr_rx_hdr2:  csr_readdata <= rx_hdr_q[2];
        csr_tx_hdr0:  csr_readdata <= tx_hdr_q[0];
        csr_tx_hdr1:  csr_readdata <= tx_hdr_q[1];
        csr_tx_hdr2:  csr_readdata <= tx_hdr_q[2];
        default:      csr_readdata <= 32'hffff_ffff;  // unmapped
      endcase
    end
  end

  // each counted sop beat is one whole completion
  tx_whole_packet: assert property (
    @(posedge clk) disable iff (reset) tx.valid |-> (tx.sop && tx.eop)
  );

endmodule

`default_nettype wire

/* hdl/pcie_data_top.sv */
`timescale 1ns/100ps
`default_nettype none

// receive-and-reply data block on the 256-bit avalon-st side of the hard ip
module pcie_data_top #(
  parameter pcie_pkg::pcie_id_t COMPLETER_ID = pcie_pkg::default_completer_id
) (
  input  logic                clk,
  input  logic                reset,
  // rx stream from the hard ip
  input  pcie_pkg::tlp_data_t rx_st_data,
  input  logic [1:0]          rx_st_empty,  // unused, header is always in beat 0
  input  logic                rx_st_error,  // unused, no error reporting
  input  logic                rx_st_startofpacket,
  input  logic                rx_st_endofpacket,  // unused, payload beats ignored
  input  logic                rx_st_valid,
  output logic                rx_st_ready,
  // tx stream to the hard ip
  output pcie_pkg::tlp_data_t tx_st_data,
  output logic                tx_st_startofpacket,
  output logic                tx_st_endofpacket,
  output logic [1:0]          tx_st_empty,
  output logic                tx_st_error,
  output logic                tx_st_valid,
  // status port
  input  logic                csr_read,
  input  pcie_pkg::csr_addr_t csr_address,
  output pcie_pkg::dword_t    csr_readdata
);

  tlp_hdr_if hdr_if ();
  tlp_tx_if  tx_if ();

  // never stalls, ready only drops in reset
  assign rx_st_ready = !reset;

  assign tx_st_data          = tx_if.data;
  assign tx_st_startofpacket = tx_if.sop;
  assign tx_st_endofpacket   = tx_if.eop;
  assign tx_st_empty         = tx_if.empty;
  assign tx_st_valid         = tx_if.valid;
  assign tx_st_error         = 1'b0;  // completions are never aborted

  tlp_rx_decoder tlp_rx_decoder_inst (
    .clk      (clk),
    .reset    (reset),
    .rx_data  (rx_st_data),
    .rx_valid (rx_st_valid),
    .rx_sop   (rx_st_startofpacket),
    .hdr      (hdr_if.src)
  );

  cpl_builder #(
    .COMPLETER_ID (COMPLETER_ID)
  ) cpl_builder_inst (
    .clk   (clk),
    .reset (reset),
    .hdr   (hdr_if.dst),
    .tx    (tx_if.src)
  );

  tlp_csr #(
    .COMPLETER_ID (COMPLETER_ID)
  ) tlp_csr_inst (
    .clk          (clk),
    .reset        (reset),
    .hdr          (hdr_if.dst),
    .tx           (tx_if.mon),
    .csr_read     (csr_read),
    .csr_address  (csr_address),
    .csr_readdata (csr_readdata)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

// free running clock, reset released on a rising edge
module tb_clock_gen #(
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

/* testbench/tb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

// expectations arrive in lockstep with the stimulus and are sampled on the rising edge
module tb_checker (
  input logic                clk,
  input logic                reset,
  input logic                rx_st_ready,
  input pcie_pkg::tlp_data_t tx_st_data,
  input logic                tx_st_startofpacket,
  input logic                tx_st_endofpacket,
  input logic [1:0]          tx_st_empty,
  input logic                tx_st_error,
  input logic                tx_st_valid,
  input logic                csr_read,
  input pcie_pkg::csr_addr_t csr_address,
  input pcie_pkg::dword_t    csr_readdata,
  input logic                exp_valid,  // this header beat needs a completion
  input pcie_pkg::tlp_data_t exp_data,
  input pcie_pkg::dword_t    exp_csr     // value for the read in this cycle
);
  import pcie_pkg::*;

  tlp_data_t exp_q[$];      // completions still to come with the oldest first
  int        due_q[$];      // cycle each one has to appear in
  int        cycle;
  int        outstanding;   // completions plus reads not compared yet
  int        error_count;
  int        check_count;
  int        test_count;
  int        test_errors;
  int        test_checks;
  string     test_name;
  logic      csr_pending;
  csr_addr_t csr_idx;
  dword_t    csr_exp;
  logic      past_first_edge;  // tx regs are unknown before the first reset edge

  initial begin
    cycle = 0;
    outstanding = 0;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    csr_pending = 1'b0;
    past_first_edge = 1'b0;
  end

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic end_test();
    test_count++;
    if (test_errors == 0) begin
      $display("test %s passed, %0d checks", test_name, test_checks);
    end else begin
      $display("test %s failed, %0d of %0d checks wrong", test_name, test_errors, test_checks);
    end
  endtask

  task automatic report_summary();
    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
  endtask

  task automatic compare_value(input string what, input logic [255:0] expected,
                               input logic [255:0] actual);
    check_count++;
    test_checks++;
    if (actual !== expected) begin
      error_count++;
      test_errors++;
      $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    check_count++;
    test_checks++;
    error_count++;
    test_errors++;
    $display("[%s] %s", test_name, what);
  endtask

  always @(posedge clk) begin : watch
    int delta;  // change of outstanding in this cycle
    delta = 0;
    if (reset) begin
      compare_value("rx_st_ready in reset", 1'b0, rx_st_ready);
      if (past_first_edge) compare_value("tx_st_valid in reset", 1'b0, tx_st_valid);
    end else begin
      compare_value("rx_st_ready", 1'b1, rx_st_ready);
      // pop before push since the front is always the older request
      if (tx_st_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          report_failure("completion sent while no memory read was waiting for one");
        end else begin
          compare_value("completion cycle", due_q[0], cycle);
          compare_value("completion data", exp_q[0], tx_st_data);
          compare_value("sop eop error", 3'b110,
                        {tx_st_startofpacket, tx_st_endofpacket, tx_st_error});
          compare_value("tx_st_empty", 2'd2, tx_st_empty);
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
          delta--;
        end
      end else if (tx_st_valid !== 1'b0) begin
        report_failure("tx_st_valid is unknown");
      end else if (exp_q.size() != 0 && due_q[0] <= cycle) begin
        report_failure("no completion 2 cycles after a memory read header");
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
        delta--;
      end
      if (exp_valid) begin
        exp_q.push_back(exp_data);
        due_q.push_back(cycle + 2);  // fixed latency header to tx
        delta++;
      end
      if (csr_pending) begin
        compare_value($sformatf("csr[%0d]", csr_idx), csr_exp, csr_readdata);
        delta--;
      end
      if (csr_read) delta++;
    end
    csr_pending <= !reset && csr_read;  // read data shows one cycle later
    csr_idx <= csr_address;
    csr_exp <= exp_csr;
    past_first_edge <= 1'b1;
    cycle <= cycle + 1;
    outstanding <= outstanding + delta;
  end

endmodule

`default_nettype wire

/* testbench/tb_pcie_data.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pcie_data;
  import pcie_pkg::*;

  localparam pcie_id_t completer_id = 16'hb300;  // dut default of bus b3 dev 0 fn 0
  localparam int reset_cycles = 10;
  // beats per test including csr reads and idle gaps
  localparam int beats = 8 + 24 + 8 + 9 + 12 + 8;
  localparam int timeout_cycles = reset_cycles + beats * 4 + 100;

  logic      clk;
  logic      reset;
  tlp_data_t rx_st_data;
  logic [1:0] rx_st_empty;
  logic      rx_st_error;
  logic      rx_st_startofpacket;
  logic      rx_st_endofpacket;
  logic      rx_st_valid;
  logic      rx_st_ready;
  tlp_data_t tx_st_data;
  logic      tx_st_startofpacket;
  logic      tx_st_endofpacket;
  logic [1:0] tx_st_empty;
  logic      tx_st_error;
  logic      tx_st_valid;
  logic      csr_read;
  csr_addr_t csr_address;
  dword_t    csr_readdata;
  logic      exp_valid;
  tlp_data_t exp_data;
  dword_t    exp_csr;

  integer    seed;
  int        cycle_count;
  int        rx_total;   // header beats sent since reset
  int        mrd_total;
  tlp_data_t last_rx;
  tlp_data_t last_cpl;

  tb_clock_gen #(.reset_cycles(reset_cycles)) clock_gen_inst (.clk(clk), .reset(reset));

  pcie_data_top pcie_data_top_inst (
    .clk                 (clk),
    .reset               (reset),
    .rx_st_data          (rx_st_data),
    .rx_st_empty         (rx_st_empty),
    .rx_st_error         (rx_st_error),
    .rx_st_startofpacket (rx_st_startofpacket),
    .rx_st_endofpacket   (rx_st_endofpacket),
    .rx_st_valid         (rx_st_valid),
    .rx_st_ready         (rx_st_ready),
    .tx_st_data          (tx_st_data),
    .tx_st_startofpacket (tx_st_startofpacket),
    .tx_st_endofpacket   (tx_st_endofpacket),
    .tx_st_empty         (tx_st_empty),
    .tx_st_error         (tx_st_error),
    .tx_st_valid         (tx_st_valid),
    .csr_read            (csr_read),
    .csr_address         (csr_address),
    .csr_readdata        (csr_readdata)
  );

  tb_checker tb_checker_inst (
    .clk                 (clk),
    .reset               (reset),
    .rx_st_ready         (rx_st_ready),
    .tx_st_data          (tx_st_data),
    .tx_st_startofpacket (tx_st_startofpacket),
    .tx_st_endofpacket   (tx_st_endofpacket),
    .tx_st_empty         (tx_st_empty),
    .tx_st_error         (tx_st_error),
    .tx_st_valid         (tx_st_valid),
    .csr_read            (csr_read),
    .csr_address         (csr_address),
    .csr_readdata        (csr_readdata),
    .exp_valid           (exp_valid),
    .exp_data            (exp_data),
    .exp_csr             (exp_csr)
  );

  // reference CplD beat for a one dword read
  function automatic tlp_data_t expected_cpl(input pcie_id_t req_id, input tlp_tag_t tag,
                                             input tlp_addr_t addr);
    tlp_data_t beat;
    beat = '0;
    beat[31:0]   = {3'b010, 5'b01010, 14'h0, 10'd1};        // CplD of length 1
    beat[63:32]  = {completer_id, 3'b000, 1'b0, 12'd4};     // successful with 4 bytes
    beat[95:64]  = {req_id, tag, 1'b0, addr[6:0]};
    beat[127:96] = {tag, req_id, addr[7:0]};                // echoed payload
    return beat;
  endfunction

  function automatic tlp_data_t request_beat(input logic [2:0] fmt, input pcie_id_t req_id,
                                             input tlp_tag_t tag, input tlp_addr_t addr,
                                             input tlp_data_t filler);
    tlp_data_t beat;
    beat = filler;  // junk in unused dwords
    beat[31:0]  = {fmt, 5'b00000, 14'h0, 10'd1};
    beat[63:32] = {req_id, tag, 8'h0f};
    if (fmt[0]) begin
      beat[95:64]  = addr[63:32];
      beat[127:96] = addr[31:0];
    end else begin
      beat[95:64] = addr[31:0];
    end
    return beat;
  endfunction

  task automatic random_beat(output tlp_data_t beat);
    for (int i = 0; i < 8; i++) beat[i*32 +: 32] = $random(seed);
  endtask

  task automatic send_beat(input tlp_data_t beat, input logic valid, input logic sop,
                           input logic cpl_due, input tlp_data_t cpl);
    @(posedge clk);
    rx_st_data          <= beat;
    rx_st_valid         <= valid;
    rx_st_startofpacket <= sop;
    rx_st_endofpacket   <= valid;  // all beats here are single beat packets
    csr_read            <= 1'b0;
    exp_valid           <= cpl_due;
    exp_data            <= cpl;
    if (valid && sop) begin
      rx_total++;
      last_rx = beat;
    end
    if (cpl_due) begin
      mrd_total++;
      last_cpl = cpl;
    end
  endtask

  task automatic send_mrd(input logic is_4dw);
    tlp_data_t filler;
    pcie_id_t  req_id;
    tlp_tag_t  tag;
    tlp_addr_t addr;
    random_beat(filler);
    req_id = $random(seed);
    tag = $random(seed);
    addr[63:32] = is_4dw ? $random(seed) : 32'h0;
    addr[31:0] = $random(seed);
    addr[1:0] = 2'b00;  // dword aligned
    send_beat(request_beat({2'b00, is_4dw}, req_id, tag, addr, filler), 1'b1, 1'b1, 1'b1,
              expected_cpl(req_id, tag, addr));
  endtask

  task automatic send_other(input logic [2:0] fmt, input logic [4:0] tlp_type);
    tlp_data_t beat;
    random_beat(beat);
    beat[31:24] = {fmt, tlp_type};
    send_beat(beat, 1'b1, 1'b1, 1'b0, '0);
  endtask

  task automatic read_csr(input csr_addr_t idx, input dword_t value);
    @(posedge clk);
    rx_st_valid         <= 1'b0;
    rx_st_startofpacket <= 1'b0;
    rx_st_endofpacket   <= 1'b0;
    exp_valid           <= 1'b0;
    csr_read            <= 1'b1;
    csr_address         <= idx;
    exp_csr             <= value;
  endtask

  // idle the bus and wait for the checker to run dry
  task automatic settle();
    @(posedge clk);
    rx_st_valid         <= 1'b0;
    rx_st_startofpacket <= 1'b0;
    rx_st_endofpacket   <= 1'b0;
    exp_valid           <= 1'b0;
    csr_read            <= 1'b0;
    @(posedge clk);
    while (tb_checker_inst.outstanding != 0) @(posedge clk);
    repeat (3) @(posedge clk);  // a stray completion would land in here
    @(negedge clk);
  endtask

  initial begin
    tlp_data_t beat;
    seed = 32'h8f01_a264;
    rx_st_data = '0;
    rx_st_empty = 2'd0;
    rx_st_error = 1'b0;
    rx_st_startofpacket = 1'b0;
    rx_st_endofpacket = 1'b0;
    rx_st_valid = 1'b0;
    csr_read = 1'b0;
    csr_address = '0;
    exp_valid = 1'b0;
    exp_data = '0;
    exp_csr = '0;
    rx_total = 0;
    mrd_total = 0;
    last_rx = '0;
    last_cpl = '0;

    tb_checker_inst.begin_test("reset_state");
    @(posedge clk);
    while (reset) @(posedge clk);
    for (int i = 1; i <= 8; i++) read_csr(csr_addr_t'(i), 32'h0);
    settle();
    tb_checker_inst.end_test();

    tb_checker_inst.begin_test("mrd_3dw");
    for (int i = 0; i < 16; i++) begin
      send_mrd(1'b0);
      if (i >= 8) send_beat('0, 1'b0, 1'b0, 1'b0, '0);  // gaps in the second half
    end
    settle();
    tb_checker_inst.end_test();

    tb_checker_inst.begin_test("mrd_4dw");
    for (int i = 0; i < 8; i++) send_mrd(1'b1);
    settle();
    tb_checker_inst.end_test();

    tb_checker_inst.begin_test("no_completion");
    send_other(3'b010, 5'b00000);  // MWr 3dw
    send_other(3'b011, 5'b00000);  // MWr 4dw
    send_other(3'b000, 5'b01010);  // Cpl
    send_other(3'b010, 5'b01010);  // CplD
    send_other(3'b000, 5'b00100);  // CfgRd0
    send_other(3'b010, 5'b00100);  // CfgWr0
    send_other(3'b000, 5'b00001);  // MRdLk
    random_beat(beat);
    beat[31:24] = 8'h00;           // read header where no header belongs
    send_beat(beat, 1'b1, 1'b0, 1'b0, '0);
    send_beat(beat, 1'b0, 1'b0, 1'b0, '0);
    settle();
    tb_checker_inst.end_test();

    tb_checker_inst.begin_test("csr_counters");
    send_mrd(1'b0);
    send_other(3'b010, 5'b00000);
    send_mrd(1'b1);
    send_other(3'b010, 5'b01010);  // last rx header differs from last completion
    settle();
    read_csr(4'd1, rx_total);
    read_csr(4'd2, mrd_total);
    read_csr(4'd3, last_rx[31:0]);
    read_csr(4'd4, last_rx[63:32]);
    read_csr(4'd5, last_rx[95:64]);
    read_csr(4'd6, last_cpl[31:0]);
    read_csr(4'd7, last_cpl[63:32]);
    read_csr(4'd8, last_cpl[95:64]);
    settle();
    tb_checker_inst.end_test();

    tb_checker_inst.begin_test("csr_id_unmapped");
    read_csr(4'd0, {16'h0, completer_id});
    for (int i = 9; i <= 15; i++) read_csr(csr_addr_t'(i), 32'hffff_ffff);
    settle();
    tb_checker_inst.end_test();

    tb_checker_inst.report_summary();
    if (tb_checker_inst.error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial cycle_count = 0;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout, run still going after %0d cycles", timeout_cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* flist.f */
hdl/pcie_pkg.sv
hdl/tlp_hdr_if.sv
hdl/tlp_tx_if.sv
hdl/tlp_rx_decoder.sv
hdl/cpl_builder.sv
hdl/tlp_csr.sv
hdl/pcie_data_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_pcie_data.sv
